/* Makefile */
# Verilator build and run of the synthCore testbench
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP ?= tbSynthCore
FILELIST ?= synthCore.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= all tests passed
VFLAGS ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* phaseBank.sv */
`timescale 1ns/10ps
`default_nettype none

module phaseBank
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input voiceTag_t step,
	input logic [numVoices-1:0][phaseW-1:0] phaseIncr,
	input logic [numVoices-1:0] retrig,
	output phaseTap_t tap
);

	// One accumulator per voice
	logic [numVoices-1:0][phaseW-1:0] phase;

	// ============================================================
	// Accumulators
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			phase <= '0;
		end else begin
			// Step the addressed voice after its phase was sampled
			if (step.valid) begin
				phase[step.idx] <= phase[step.idx] + phaseIncr[step.idx];
			end
			// Retrigger wins over a step to the same voice
			for (int i = 0; i < numVoices; i++) begin
				if (retrig[i]) begin
					phase[i] <= '0;
				end
			end
		end
	end

	// ============================================================
	// Tap register
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			tap <= '0;
		end else begin
			tap.tag <= step;
			// Current phase, before this step's increment
			tap.phase <= phase[step.idx][phaseW-1 -: sampleW];
		end
	end

endmodule

`default_nettype wire

/* synthCore.f */
synthPkg.sv
voiceConfig.sv
voiceSequencer.sv
phaseBank.sv
waveShaper.sv
voiceMixer.sv
synthCore.sv
tbSynthCore.sv

/* synthCore.sv */
`timescale 1ns/10ps
`default_nettype none

module synthCore
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input logic sampleTick,
	input cfgWrite_t cfg,
	output logic signed [sampleW-1:0] sampleOut,
	output logic sampleValid
);

	// Config to datapath
	logic [numVoices-1:0][phaseW-1:0] phaseIncr;
	waveSel_t [numVoices-1:0] waves;
	logic [sampleW-1:0] amplitude;
	logic [numVoices-1:0] retrig;

	// Pipeline stages
	voiceTag_t step;
	phaseTap_t tap;
	voiceSample_t sample;

	// ============================================================
	// Control and config
	// ============================================================
	voiceSequencer sequencer (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.sampleTick(sampleTick),
		.step(step)
	);

	voiceConfig config0 (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.cfg(cfg),
		.phaseIncr(phaseIncr),
		.waves(waves),
		.amplitude(amplitude),
		.retrig(retrig)
	);

	// ============================================================
	// Datapath
	// ============================================================
	phaseBank phases (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.step(step),
		.phaseIncr(phaseIncr),
		.retrig(retrig),
		.tap(tap)
	);

	waveShaper shaper (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.tap(tap),
		.waves(waves),
		.sample(sample)
	);

	voiceMixer mixer (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.sample(sample),
		.amplitude(amplitude),
		.sampleOut(sampleOut),
		.sampleValid(sampleValid)
	);

endmodule

`default_nettype wire

/* synthPkg.sv */
`default_nettype none

package synthPkg;

	// ============================================================
	// Sizes
	// ============================================================

	// Voice count and index width
	localparam int numVoices = 4;
	localparam int voiceIdxW = 2;

	// Phase accumulator width
	localparam int phaseW = 32;

	// Sample and amplitude width
	localparam int sampleW = 16;
	localparam int noteW = 4;

	// Increment is (note+1) << incrShift
	localparam int incrShift = 24;

	// Mixed sum scaled down before truncation
	localparam int mixShift = 17;

	// Signed sample times unsigned amplitude
	localparam int prodW = 2 * sampleW + 1;
	// Room for the sum of all voices
	localparam int accW = prodW + voiceIdxW;

	// ============================================================
	// Codes and payloads
	// ============================================================

	typedef enum logic [1:0] {
		waveOff = 2'd0,
		waveSaw = 2'd1,
		waveSquare = 2'd2,
		waveTri = 2'd3
	} waveSel_t;

	// Write goes to one voice or to the global amplitude
	typedef enum logic {
		targetVoice = 1'b0,
		targetAmp = 1'b1
	} cfgTarget_t;

	// Travels with every pipeline item
	typedef struct packed {
		logic valid;
		logic [voiceIdxW-1:0] idx;
		logic first;
		logic last;
	} voiceTag_t;

	// Top phase bits of one voice
	typedef struct packed {
		voiceTag_t tag;
		logic [sampleW-1:0] phase;
	} phaseTap_t;

	typedef struct packed {
		voiceTag_t tag;
		logic signed [sampleW-1:0] sample;
	} voiceSample_t;

	// Single-cycle configuration write
	typedef struct packed {
		logic strobe;
		cfgTarget_t target;
		logic [voiceIdxW-1:0] voice;
		logic [noteW-1:0] note;
		waveSel_t wave;
		logic [sampleW-1:0] amp;
	} cfgWrite_t;

endpackage

`default_nettype wire

/* tbSynthCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tbSynthCore
	import synthPkg::*;
();

	// Tests take about 850 cycles
	localparam int maxCycles = 4000;
	// Worst frame needs 7 cycles
	localparam int drainLimit = 40;

	logic MAX10_CLK2_50;
	logic rstN;
	logic sampleTick;
	cfgWrite_t cfg;
	logic signed [sampleW-1:0] sampleOut;
	logic sampleValid;

	// Reference model state
	logic [phaseW-1:0] refPhase [numVoices];
	logic [noteW-1:0] refNote [numVoices];
	waveSel_t refWave [numVoices];
	logic [sampleW-1:0] refAmp;

	// Expected mixed samples in issue order
	logic [sampleW-1:0] expectQ [$];

	integer seed = 32'h668d5e9c;
	int errorCount = 0;
	int checkCount = 0;
	int validCount = 0;
	int cycleCount = 0;

	synthCore uut (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.sampleTick(sampleTick),
		.cfg(cfg),
		.sampleOut(sampleOut),
		.sampleValid(sampleValid)
	);

	// 8 ns period
	initial begin
		MAX10_CLK2_50 = 1'b0;
		forever #4 MAX10_CLK2_50 = ~MAX10_CLK2_50;
	end

	// ============================================================
	// Reference model
	// ============================================================
	function automatic int pickRange(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	// Signed sample from the top 16 phase bits
	function automatic int shapeSample(input logic [sampleW-1:0] p, input waveSel_t w);
		int t;
		int result;
		result = 0;
		case (w)
			waveSaw: result = int'(p) - 32768;
			waveSquare: result = p[15] ? -32767 : 32767;
			waveTri: begin
				// Falling half counts back down
				t = p[15] ? 32767 - int'(p[14:0]) : int'(p[14:0]);
				result = 2 * t - 32768;
			end
			default: result = 0;
		endcase
		return result;
	endfunction

	// Model one frame and advance every voice
	function automatic logic [sampleW-1:0] modelFrame();
		longint sum;
		longint scaled;
		sum = 0;
		for (int v = 0; v < numVoices; v++) begin
			sum += longint'(shapeSample(refPhase[v][phaseW-1 -: sampleW], refWave[v]))
				* longint'(refAmp);
			refPhase[v] = refPhase[v] + ((phaseW'(refNote[v]) + phaseW'(1)) << incrShift);
		end
		scaled = sum >>> mixShift;
		return scaled[sampleW-1:0];
	endfunction

	// ============================================================
	// Drive helpers
	// ============================================================
	// Inputs and checks sit 1 ns past each edge
	task automatic nextCycle();
		logic [sampleW-1:0] expected;
		@(posedge MAX10_CLK2_50);
		#1;
		if (sampleValid) begin
			validCount++;
			checkCount++;
			if (expectQ.size() == 0) begin
				errorCount++;
				$display("sampleValid was high with no frame pending");
			end else begin
				expected = expectQ.pop_front();
				if (sampleOut !== expected) begin
					errorCount++;
					$display("FAIL sampleOut: expected %h, got %h", expected, sampleOut);
				end
			end
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) nextCycle();
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && waited < drainLimit) begin
			nextCycle();
			waited++;
		end
		if (expectQ.size() != 0) begin
			errorCount++;
			$display("%0d frames never produced sampleValid", expectQ.size());
			expectQ.delete();
		end
	endtask

	task automatic pulseTick();
		expectQ.push_back(modelFrame());
		sampleTick = 1'b1;
		nextCycle();
		sampleTick = 1'b0;
	endtask

	task automatic runFrames(input int n);
		repeat (n) begin
			pulseTick();
			waitDrain();
		end
	endtask

	// Voice write also zeroes that voice's phase
	task automatic writeVoice(input int v, input logic [noteW-1:0] note, input waveSel_t wave);
		waitDrain();
		cfg.strobe = 1'b1;
		cfg.target = targetVoice;
		cfg.voice = voiceIdxW'(v);
		cfg.note = note;
		cfg.wave = wave;
		nextCycle();
		cfg = '0;
		refNote[v] = note;
		refWave[v] = wave;
		refPhase[v] = '0;
		// Increment and retrigger settle
		idleCycles(3);
	endtask

	task automatic writeAmp(input logic [sampleW-1:0] amp);
		waitDrain();
		cfg.strobe = 1'b1;
		cfg.target = targetAmp;
		cfg.amp = amp;
		nextCycle();
		cfg = '0;
		refAmp = amp;
		idleCycles(2);
	endtask

	task automatic silenceVoices();
		for (int v = 0; v < numVoices; v++) begin
			writeVoice(v, '0, waveOff);
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic latencyAfterReset();
		int waited;
		idleCycles(10);
		pulseTick();
		waited = 1;
		while (!sampleValid && waited < 20) begin
			nextCycle();
			waited++;
		end
		checkCount++;
		if (waited != 7) begin
			errorCount++;
			$display("FAIL sampleValid latency: expected %h, got %h", 7, waited);
		end
		checkCount++;
		if (sampleOut !== '0) begin
			errorCount++;
			$display("FAIL sampleOut: expected %h, got %h", 16'h0, sampleOut);
		end
		nextCycle();
		checkCount++;
		if (sampleValid !== 1'b0) begin
			errorCount++;
			$display("FAIL sampleValid: expected %h, got %h", 1'b0, sampleValid);
		end
	endtask

	// High notes so the phase wraps within 20 frames
	task automatic sawVoice();
		silenceVoices();
		writeAmp(sampleW'(pickRange('h1000, 'h7FFF)));
		writeVoice(0, noteW'(pickRange(12, 15)), waveSaw);
		runFrames(20);
	endtask

	task automatic squareAndTriangle();
		silenceVoices();
		writeAmp(sampleW'(pickRange('h1000, 'h7FFF)));
		writeVoice(2, noteW'(pickRange(0, 15)), waveSquare);
		runFrames(20);
		writeVoice(2, '0, waveOff);
		writeVoice(3, noteW'(pickRange(0, 15)), waveTri);
		runFrames(20);
		// All voices off gives silence
		writeVoice(3, '0, waveOff);
		runFrames(2);
	endtask

	// Gaps of four would land in the busy window
	task automatic fourVoiceMix();
		for (int v = 0; v < numVoices; v++) begin
			writeVoice(v, noteW'(pickRange(0, 15)), waveSel_t'(2'(pickRange(0, 3))));
		end
		writeAmp(sampleW'(pickRange('h1000, 'h7FFF)));
		repeat (30) begin
			pulseTick();
			idleCycles(pickRange(5, 8) - 1);
		end
		waitDrain();
	endtask

	task automatic retriggerPhase();
		logic [noteW-1:0] note;
		note = noteW'(pickRange(0, 15));
		silenceVoices();
		writeVoice(1, note, waveSaw);
		runFrames(5);
		// Same settings restart the phase at zero
		writeVoice(1, note, waveSaw);
		runFrames(3);
	endtask

	task automatic ignoredTick();
		int validsBefore;
		validsBefore = validCount;
		pulseTick();
		nextCycle();
		// Second request falls inside the busy window
		sampleTick = 1'b1;
		nextCycle();
		sampleTick = 1'b0;
		idleCycles(15);
		checkCount++;
		if (validCount - validsBefore != 1) begin
			errorCount++;
			$display("tick pair gave %0d sampleValid pulses instead of one",
				validCount - validsBefore);
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		rstN = 1'b0;
		sampleTick = 1'b0;
		cfg = '0;
		for (int v = 0; v < numVoices; v++) begin
			refPhase[v] = '0;
			refNote[v] = '0;
			refWave[v] = waveOff;
		end
		refAmp = '0;
		repeat (16) @(posedge MAX10_CLK2_50);
		#1;
		rstN = 1'b1;
		latencyAfterReset();
		sawVoice();
		squareAndTriangle();
		fourVoiceMix();
		retriggerPhase();
		ignoredTick();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Run limit
	initial begin
		while (cycleCount < maxCycles) begin
			@(posedge MAX10_CLK2_50);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", maxCycles);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* voiceConfig.sv */
`timescale 1ns/10ps
`default_nettype none

module voiceConfig
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input cfgWrite_t cfg,
	output logic [numVoices-1:0][phaseW-1:0] phaseIncr,
	output waveSel_t [numVoices-1:0] waves,
	output logic [sampleW-1:0] amplitude,
	output logic [numVoices-1:0] retrig
);

	// Note index per voice
	logic [numVoices-1:0][noteW-1:0] notes;

	// ============================================================
	// Write decode
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			notes <= '0;
			for (int i = 0; i < numVoices; i++) begin
				waves[i] <= waveOff;
			end
			amplitude <= '0;
			retrig <= '0;
		end else begin
			// Pulse lasts one cycle only
			retrig <= '0;
			if (cfg.strobe) begin
				if (cfg.target == targetVoice) begin
					notes[cfg.voice] <= cfg.note;
					waves[cfg.voice] <= cfg.wave;
					// Restart this voice's phase
					retrig[cfg.voice] <= 1'b1;
				end else begin
					amplitude <= cfg.amp;
				end
			end
		end
	end

	// Increment follows the note one cycle later
	always_ff @(posedge MAX10_CLK2_50) begin
		for (int i = 0; i < numVoices; i++) begin
			phaseIncr[i] <= (phaseW'(notes[i]) + phaseW'(1)) << incrShift;
		end
	end

endmodule

`default_nettype wire

/* voiceMixer.sv */
`timescale 1ns/10ps
`default_nettype none

module voiceMixer
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input voiceSample_t sample,
	input logic [sampleW-1:0] amplitude,
	output logic signed [sampleW-1:0] sampleOut,
	output logic sampleValid
);

	logic signed [prodW-1:0] prod;
	// Running frame sum
	logic signed [accW-1:0] acc;
	logic signed [accW-1:0] frameSum;
	logic signed [accW-1:0] scaled;

	// Unsigned amplitude gets a zero sign bit
	assign prod = prodW'($signed(sample.sample)) * prodW'($signed({1'b0, amplitude}));

	// First voice of a frame starts from zero
	assign frameSum = (sample.tag.first ? accW'(0) : acc) + accW'(prod);
	assign scaled = frameSum >>> mixShift;

	// ============================================================
	// Accumulate
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50) begin
		if (sample.tag.valid) begin
			acc <= frameSum;
		end
	end

	// ============================================================
	// Output
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			sampleOut <= '0;
			sampleValid <= 1'b0;
		end else begin
			sampleValid <= sample.tag.valid && sample.tag.last;
			// Hold the previous sample between frames
			if (sample.tag.valid && sample.tag.last) begin
				sampleOut <= scaled[sampleW-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* voiceSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module voiceSequencer
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input logic sampleTick,
	output voiceTag_t step
);

	// High from the accepting edge until one cycle after the last voice
	logic busy;
	// Next voice to issue
	logic [voiceIdxW-1:0] voiceCnt;

	// ============================================================
	// Request to voice steps
	// ============================================================
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			voiceCnt <= '0;
			step <= '0;
		end else if (!busy) begin
			if (sampleTick) begin
				// Voice 0 opens the frame
				busy <= 1'b1;
				voiceCnt <= voiceIdxW'(1);
				step.valid <= 1'b1;
				step.idx <= '0;
				step.first <= 1'b1;
				step.last <= 1'b0;
			end else begin
				step <= '0;
			end
		end else if (step.last) begin
			// Frame issued, drop busy one cycle later
			busy <= 1'b0;
			step <= '0;
		end else begin
			step.valid <= 1'b1;
			step.idx <= voiceCnt;
			step.first <= 1'b0;
			step.last <= (voiceCnt == voiceIdxW'(numVoices - 1));
			// Wraps back to 0 after the last voice
			voiceCnt <= voiceCnt + voiceIdxW'(1);
		end
	end

endmodule

`default_nettype wire

/* waveShaper.sv */
`timescale 1ns/10ps
`default_nettype none

module waveShaper
	import synthPkg::*;
(
	input logic MAX10_CLK2_50,
	input logic rstN,
	input phaseTap_t tap,
	input waveSel_t [numVoices-1:0] waves,
	output voiceSample_t sample
);

	waveSel_t wave;
	// Folded low bits for the triangle
	logic [sampleW-2:0] triFold;
	logic [sampleW-1:0] triDbl;
	logic signed [sampleW-1:0] shaped;

	// Code of the voice that is in this stage
	assign wave = waves[tap.tag.idx];

	// Falling half mirrors the rising half
	assign triFold = tap.phase[sampleW-1] ? ~tap.phase[sampleW-2:0] : tap.phase[sampleW-2:0];
	assign triDbl = {triFold, 1'b0};

	// ============================================================
	// Shape select
	// ============================================================
	always_comb begin
		case (wave)
			waveSaw: shaped = {~tap.phase[sampleW-1], tap.phase[sampleW-2:0]};
			// Symmetric full scale, -32767 and +32767
			waveSquare: shaped = tap.phase[sampleW-1] ? 16'sh8001 : 16'sh7FFF;
			waveTri: shaped = {~triDbl[sampleW-1], triDbl[sampleW-2:0]};
			default: shaped = '0;
		endcase
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			sample <= '0;
		end else begin
			sample.tag <= tap.tag;
			sample.sample <= shaped;
		end
	end

endmodule

`default_nettype wire
